//--- host_shim.f
+incdir+rtl
rtl/host_shim_pkg.sv
rtl/wr_beat_tracker.sv
rtl/c1_tx_fifo.sv
rtl/fiu_port_stage.sv
rtl/host_shim_top.sv
sim/host_shim_assert.sv
sim/host_shim_tb.sv

//--- rtl/c1_tx_fifo.sv
/*
  Write-request FIFO between the beat tracker and the fabric port stage.
  Head is shown as soon as a beat lands; almfull warns the accelerator.
*/
`include "host_shim_cfg.svh"

module c1_tx_fifo
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push,
    input  host_shim_pkg::t_c1_tx push_data,
    input  logic                  pop,
    output host_shim_pkg::t_c1_tx head,      // head.valid = not empty
    output logic                  almfull
);

    localparam int DEPTH    = `HS_FIFO_DEPTH;
    localparam int PTR_W    = $clog2(DEPTH);
    localparam int CNT_W    = $clog2(DEPTH + 1);
    localparam int AF_LEVEL = DEPTH - `HS_ALMFULL_SLACK;
    // Stored beat is the struct minus its valid bit
    localparam int ENTRY_W  = $bits(host_shim_pkg::t_c1_tx) - 1;

    logic [ENTRY_W-1:0] mem [DEPTH];   // Payload only, no reset
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               empty;
    logic               do_push;
    logic               do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;     // Push on full is lost
    assign do_pop  = pop && !empty;

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data[ENTRY_W-1:0];
        end
    end

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Idle or push and pop together
            endcase
        end
    end

    // Valid bit rebuilt from occupancy
    assign head    = host_shim_pkg::t_c1_tx'({!empty, mem[rd_ptr]});
    assign almfull = (count >= CNT_W'(AF_LEVEL));  // From the registered count

endmodule

//--- rtl/fiu_port_stage.sv
/*
  Fabric boundary of the shim. Registers reads, fabric almost-full levels
  and drained writes; responses are flopped or wired per REGISTER_INPUTS.
*/
`include "host_shim_cfg.svh"

module fiu_port_stage
#(
    parameter int REGISTER_INPUTS = `HS_REGISTER_INPUTS
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  host_shim_pkg::t_c1_tx head,            // FIFO head
    output logic                  pop,
    input  host_shim_pkg::t_c0_tx afu_c0_tx,
    output host_shim_pkg::t_c0_tx fiu_c0_tx,
    output host_shim_pkg::t_c1_tx fiu_c1_tx,
    input  logic                  fiu_c0_almfull,
    input  logic                  fiu_c1_almfull,
    output logic                  afu_c0_almfull,
    input  host_shim_pkg::t_c0_rx fiu_c0_rx,
    input  host_shim_pkg::t_c1_rx fiu_c1_rx,
    output host_shim_pkg::t_c0_rx afu_c0_rx,
    output host_shim_pkg::t_c1_rx afu_c1_rx
);

    logic fab_almfull;  // Registered fiu_c1_almfull

    // Drain the FIFO only while the fabric has room
    assign pop = head.valid && !fab_almfull;

    // --------------------------------------------------
    // Outgoing requests and almost-full levels
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        fiu_c0_tx <= afu_c0_tx;
        fiu_c1_tx <= head;
        fiu_c1_tx.valid <= pop;                     // Sent only when taken from the FIFO

        if (reset)
        begin
            fiu_c0_tx.valid <= 1'b0;
            fiu_c1_tx.valid <= 1'b0;
            fab_almfull     <= 1'b1;                // Hold writes until the level is seen
            afu_c0_almfull  <= 1'b1;
        end
        else
        begin
            fab_almfull    <= fiu_c1_almfull;
            afu_c0_almfull <= fiu_c0_almfull;
        end
    end

    // --------------------------------------------------
    // Responses
    // --------------------------------------------------
    generate
        if (REGISTER_INPUTS != 0)
        begin : g_reg_in
            always_ff @(posedge clk)
            begin
                afu_c0_rx <= fiu_c0_rx;             // One stage for timing
                afu_c1_rx <= fiu_c1_rx;
                if (reset)
                begin
                    afu_c0_rx.valid <= 1'b0;
                    afu_c1_rx.valid <= 1'b0;
                end
            end
        end
        else
        begin : g_wire_in
            always_comb
            begin
                afu_c0_rx = fiu_c0_rx;              // Same-cycle path
                afu_c1_rx = fiu_c1_rx;
            end
        end
    endgenerate

endmodule

//--- rtl/host_shim_cfg.svh
/*
  Build-time sizes and options for the host shim.
  Included by the package and by any RTL that needs a raw size.
*/
`ifndef HOST_SHIM_CFG_SVH
`define HOST_SHIM_CFG_SVH

// --------------------------------------------------
// Field widths
// --------------------------------------------------
`define HS_ADDR_W 32            // Cache-line address
`define HS_DATA_W 64            // Line payload, cut down from a full line
`define HS_MDATA_W 16           // Request tag, echoed back by the fabric

// --------------------------------------------------
// Write buffer
// --------------------------------------------------
// Entries in the c1 Tx FIFO
`define HS_FIFO_DEPTH 16

// Entries left free once afu_c1_almfull is up
// Covers beats the accelerator has already committed
`define HS_ALMFULL_SLACK 4

// --------------------------------------------------
// Response path
// --------------------------------------------------
`define HS_REGISTER_INPUTS 1    // 1 = flop responses, 0 = pass as wires

`endif

//--- rtl/host_shim_pkg.sv
/*
  Shared types for the host shim: field typedefs and the packed
  request and response structs for the c0 and c1 channels.
*/
`include "host_shim_cfg.svh"

package host_shim_pkg;

    // --------------------------------------------------
    // Field types
    // --------------------------------------------------
    typedef logic [`HS_ADDR_W-1:0]  t_line_addr;    // Line address
    typedef logic [`HS_DATA_W-1:0]  t_line_data;    // One line of data
    typedef logic [`HS_MDATA_W-1:0] t_mdata;        // Tag, returned unchanged
    typedef logic [1:0]             t_cl_num;       // Beat index in a packet

    // Packet length; the code is the index of the last beat
    typedef enum logic [1:0]
    {
        CL_LEN_1 = 2'd0,
        CL_LEN_2 = 2'd1,
        CL_LEN_4 = 2'd3
    } t_cl_len;

    // --------------------------------------------------
    // Requests, accelerator to fabric
    // --------------------------------------------------
    // Read request (c0 Tx)
    typedef struct packed
    {
        logic       valid;
        t_line_addr address;
        t_mdata     mdata;
    } t_c0_tx;

    // Write request beat (c1 Tx)
    // valid must stay the top field, the FIFO strips it off by position
    typedef struct packed
    {
        logic       valid;
        logic       sop;        // First beat of a packet
        t_cl_len    cl_len;     // Same on every beat of a packet
        t_line_addr address;
        t_line_data data;
        t_mdata     mdata;
    } t_c1_tx;

    // --------------------------------------------------
    // Responses, fabric to accelerator
    // --------------------------------------------------
    // Read response (c0 Rx)
    typedef struct packed
    {
        logic       valid;
        t_mdata     mdata;
        t_line_data data;
    } t_c0_rx;

    // Write response (c1 Rx)
    typedef struct packed
    {
        logic   valid;
        t_mdata mdata;
    } t_c1_rx;

endpackage

//--- rtl/host_shim_top.sv
/*
  Host shim top: accelerator ports on one side, fabric ports on the other.
  Writes go tracker -> FIFO -> port stage; reads and responses via the stage.
*/
module host_shim_top
(
    input  logic                  clk,
    input  logic                  reset,

    // Accelerator side
    input  host_shim_pkg::t_c0_tx afu_c0_tx,
    input  host_shim_pkg::t_c1_tx afu_c1_tx,
    input  logic                  split_writes,    // Debug, 1 = single-line writes
    output host_shim_pkg::t_c0_rx afu_c0_rx,
    output host_shim_pkg::t_c1_rx afu_c1_rx,
    output logic                  afu_c1_almfull,  // From the write FIFO level
    output logic                  afu_c0_almfull,
    output logic                  beat_error,      // Sticky SOP phase error

    // Fabric side
    output host_shim_pkg::t_c0_tx fiu_c0_tx,
    output host_shim_pkg::t_c1_tx fiu_c1_tx,
    input  host_shim_pkg::t_c0_rx fiu_c0_rx,
    input  host_shim_pkg::t_c1_rx fiu_c1_rx,
    input  logic                  fiu_c0_almfull,
    input  logic                  fiu_c1_almfull
);

    host_shim_pkg::t_c1_tx trk_c1_tx;   // Tracker out, valid = push
    host_shim_pkg::t_c1_tx fifo_head;
    logic                  fifo_pop;

    // --------------------------------------------------
    // Producer, buffer, consumer
    // --------------------------------------------------
    wr_beat_tracker i_wr_beat_tracker (
        .clk          (clk),
        .reset        (reset),
        .split_writes (split_writes),
        .afu_c1_tx    (afu_c1_tx),
        .trk_c1_tx    (trk_c1_tx),
        .beat_error   (beat_error)
    );

    c1_tx_fifo i_c1_tx_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (trk_c1_tx.valid),
        .push_data (trk_c1_tx),
        .pop       (fifo_pop),
        .head      (fifo_head),
        .almfull   (afu_c1_almfull)
    );

    fiu_port_stage i_fiu_port_stage (
        .clk            (clk),
        .reset          (reset),
        .head           (fifo_head),
        .pop            (fifo_pop),
        .afu_c0_tx      (afu_c0_tx),
        .fiu_c0_tx      (fiu_c0_tx),
        .fiu_c1_tx      (fiu_c1_tx),
        .fiu_c0_almfull (fiu_c0_almfull),
        .fiu_c1_almfull (fiu_c1_almfull),
        .afu_c0_almfull (afu_c0_almfull),
        .fiu_c0_rx      (fiu_c0_rx),
        .fiu_c1_rx      (fiu_c1_rx),
        .afu_c0_rx      (afu_c0_rx),
        .afu_c1_rx      (afu_c1_rx)
    );

endmodule

//--- rtl/wr_beat_tracker.sv
/*
  Write beat tracker on the c1 Tx path. Counts beats of multi-line
  writes, flags out-of-phase SOP, and can split packets into single lines.
*/
module wr_beat_tracker
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  split_writes,  // Debug level, 1 = single-line writes
    input  host_shim_pkg::t_c1_tx afu_c1_tx,
    output host_shim_pkg::t_c1_tx trk_c1_tx,     // Feeds the FIFO, valid is the push
    output logic                  beat_error     // Sticky SOP phase error
);

    host_shim_pkg::t_cl_num beat_num;  // Index of the next expected beat
    logic                   last_beat;
    logic                   sop_expected;

    assign last_beat    = (beat_num == host_shim_pkg::t_cl_num'(afu_c1_tx.cl_len));
    assign sop_expected = (beat_num == '0);

    // --------------------------------------------------
    // Beat counter and phase check
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beat_num   <= '0;
            beat_error <= 1'b0;
        end
        else if (afu_c1_tx.valid)
        begin
            if (last_beat)
            begin
                beat_num <= '0;                 // Packet done
            end
            else
            begin
                beat_num <= beat_num + 1'b1;
            end

            // SOP must mark beat 0 and only beat 0
            if (afu_c1_tx.sop != sop_expected)
            begin
                beat_error <= 1'b1;             // Held until reset
            end
        end
    end

    // --------------------------------------------------
    // Output rewrite
    // --------------------------------------------------
    always_comb
    begin
        trk_c1_tx = afu_c1_tx;                  // Default is pass-through

        if (split_writes && afu_c1_tx.valid)
        begin
            // Each beat becomes its own one-line packet
            trk_c1_tx.sop          = 1'b1;
            trk_c1_tx.cl_len       = host_shim_pkg::CL_LEN_1;
            // Packet base is aligned, so OR gives the line of this beat
            trk_c1_tx.address[1:0] = afu_c1_tx.address[1:0] | beat_num;
        end
    end

endmodule

//--- sim/host_shim_assert.sv
/*
  Concurrent checks on the write FIFO and the fabric port stage.
  Bound into both modules; unused inputs are tied low by each bind.
*/
module host_shim_assert
(
    input logic clk,
    input logic reset,
    input logic push,           // FIFO push request
    input logic full,
    input logic fiu_c1_almfull, // Raw fabric c1 level
    input logic c0_tx_valid,
    input logic c1_tx_valid,
    input logic c0_rx_valid,
    input logic c1_rx_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // A push into a full FIFO loses the beat
    a_no_overflow: assert property (@(posedge clk) disable iff (reset) !(push && full))
        else $error("write FIFO overflow, beat dropped");

    // All strobes idle in the cycle after a reset edge
    a_idle_after_reset: assert property (@(posedge clk)
        reset |=> !c0_tx_valid && !c1_tx_valid && !c0_rx_valid && !c1_rx_valid)
        else $error("output valid high right after reset");

    // --------------------------------------------------
    // Almost-full gating
    // --------------------------------------------------
    // Level sampled at one edge, no write leaves after the next edge
    a_no_send_when_full: assert property (@(posedge clk) disable iff (reset)
        fiu_c1_almfull |-> ##2 !c1_tx_valid)
        else $error("write sent after fabric almost full was sampled");

endmodule

bind c1_tx_fifo host_shim_assert i_fifo_assert (
    .clk(clk), .reset(reset), .push(push), .full(full), .fiu_c1_almfull(1'b0),
    .c0_tx_valid(1'b0), .c1_tx_valid(head.valid), .c0_rx_valid(1'b0), .c1_rx_valid(1'b0)
);

bind fiu_port_stage host_shim_assert i_stage_assert (
    .clk(clk), .reset(reset), .push(1'b0), .full(1'b0), .fiu_c1_almfull(fiu_c1_almfull),
    .c0_tx_valid(fiu_c0_tx.valid), .c1_tx_valid(fiu_c1_tx.valid),
    .c0_rx_valid(afu_c0_rx.valid), .c1_rx_valid(afu_c1_rx.valid)
);

//--- sim/host_shim_tb.sv
/*
  Testbench for host_shim_top: xorshift stimulus on both sides, a model
  of the write path and the register stages, and one line per test.
*/
`include "host_shim_cfg.svh"

module host_shim_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int AF_LEVEL = `HS_FIFO_DEPTH - `HS_ALMFULL_SLACK;

    logic clk, reset, split_writes, beat_error;
    logic afu_c0_almfull, afu_c1_almfull, fiu_c0_almfull, fiu_c1_almfull;
    host_shim_pkg::t_c0_tx afu_c0_tx, fiu_c0_tx, exp_c0_tx;
    host_shim_pkg::t_c1_tx afu_c1_tx, fiu_c1_tx, exp_beat;
    host_shim_pkg::t_c0_rx afu_c0_rx, fiu_c0_rx, exp_c0_rx;
    host_shim_pkg::t_c1_rx afu_c1_rx, fiu_c1_rx, exp_c1_rx;

    host_shim_pkg::t_c1_tx tx_q[$];      // Beats waiting to be driven
    host_shim_pkg::t_c1_tx exp_q[$];     // Beats expected on fiu_c1_tx
    host_shim_pkg::t_cl_num m_beat;      // Model beat index
    logic [31:0] rng = 32'd94171;
    logic m_err, exp_c0_af, fab_q, fab_q_d;
    bit   rd_en, rsp_en, bp_en, hold_af;
    bit   armed = 1'b0;                  // Outputs known after the first edge
    int   beats_left, errors, n_checks, n_reads, n_beats, n_rsp, err0, chk0;

    host_shim_top i_host_shim_top (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_equal(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        n_checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // --------------------------------------------------
    // Model and output checks, sampled at the edge
    // --------------------------------------------------
    always @(posedge clk)
    begin
        if (armed)
        begin
            check_equal("fiu_c0_tx valid", fiu_c0_tx.valid, exp_c0_tx.valid);
            if (exp_c0_tx.valid)
            begin
                check_equal("fiu_c0_tx fields", fiu_c0_tx, exp_c0_tx);
                n_reads++;
            end
            check_equal("afu_c0_rx valid", afu_c0_rx.valid, exp_c0_rx.valid);
            check_equal("afu_c1_rx valid", afu_c1_rx.valid, exp_c1_rx.valid);
            if (exp_c0_rx.valid)
                check_equal("afu_c0_rx fields", afu_c0_rx, exp_c0_rx);
            if (exp_c1_rx.valid)
                check_equal("afu_c1_rx fields", afu_c1_rx, exp_c1_rx);
            n_rsp += exp_c0_rx.valid + exp_c1_rx.valid;
            check_equal("afu_c0_almfull", afu_c0_almfull, exp_c0_af);
            check_equal("beat_error", beat_error, m_err);
            if (fiu_c1_tx.valid !== 1'b0)
            begin
                check_equal("write sent while fabric almost full", fab_q_d, 1'b0);
                check_equal("fiu_c1_tx beat with none expected", exp_q.size() != 0, 1'b1);
                if (exp_q.size() != 0)
                begin
                    check_equal("fiu_c1_tx beat", fiu_c1_tx, exp_q.pop_front());
                    n_beats++;
                end
            end
            // Queue depth is the FIFO count after the previous edge
            check_equal("afu_c1_almfull", afu_c1_almfull, exp_q.size() >= AF_LEVEL);
        end
        armed   = 1'b1;
        fab_q_d = fab_q;
        if (reset)
        begin
            exp_c0_tx = '0;
            exp_c0_rx = '0;
            exp_c1_rx = '0;
            exp_c0_af = 1'b1;            // Both fabric levels reset high
            fab_q     = 1'b1;
            m_beat    = '0;
            m_err     = 1'b0;
            exp_q.delete();
        end
        else
        begin
            exp_c0_tx = afu_c0_tx;       // One register stage each
            exp_c0_rx = fiu_c0_rx;
            exp_c1_rx = fiu_c1_rx;
            exp_c0_af = fiu_c0_almfull;
            fab_q     = fiu_c1_almfull;
            if (afu_c1_tx.valid)
            begin
                exp_beat = afu_c1_tx;
                if (split_writes)
                begin
                    exp_beat.sop          = 1'b1;
                    exp_beat.cl_len       = host_shim_pkg::CL_LEN_1;
                    exp_beat.address[1:0] = afu_c1_tx.address[1:0] | m_beat;
                end
                if (afu_c1_tx.sop != (m_beat == 2'd0))
                    m_err = 1'b1;        // Sticky until reset
                m_beat = (m_beat == 2'(afu_c1_tx.cl_len)) ? 2'd0 : m_beat + 2'd1;
                exp_q.push_back(exp_beat);
            end
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic queue_packet(input bit bad_sop);
        host_shim_pkg::t_c1_tx beat;
        logic [31:0] r;
        logic [31:0] a;
        r = xorshift32();
        a = xorshift32();
        case (r % 3)
            0:       beat.cl_len = host_shim_pkg::CL_LEN_1;
            1:       beat.cl_len = host_shim_pkg::CL_LEN_2;
            default: beat.cl_len = host_shim_pkg::CL_LEN_4;
        endcase
        if (bad_sop)
            beat.cl_len = host_shim_pkg::CL_LEN_2;
        beat.valid   = 1'b1;
        beat.address = {a[31:2], 2'b00};     // Packet base, line aligned
        beat.mdata   = r[31:16];
        for (int i = 0; i <= int'(beat.cl_len); i++)
        begin
            beat.sop  = (i == 0) || (bad_sop && i == 1);
            beat.data = {xorshift32(), xorshift32()};
            tx_q.push_back(beat);
        end
    endtask

    // One cycle of drive, 1 ns after the edge
    task automatic step();
        logic [31:0] r;
        @(posedge clk);
        #1;
        r = xorshift32();
        afu_c0_tx       = {rd_en && r[0], xorshift32(), r[31:16]};
        fiu_c0_rx       = {rsp_en && r[1], r[23:8], xorshift32(), xorshift32()};
        fiu_c1_rx       = {rsp_en && r[2], r[15:0]};
        fiu_c0_almfull  = rsp_en && r[3];
        fiu_c1_almfull  = hold_af || (bp_en && r[5:4] == 2'b00);
        afu_c1_tx.valid = 1'b0;
        if (beats_left != 0)
        begin
            afu_c1_tx = tx_q.pop_front();    // Rest of a packet, back to back
            beats_left--;
        end
        else if (tx_q.size() != 0 && !afu_c1_almfull && r[6])
        begin
            afu_c1_tx  = tx_q.pop_front();
            beats_left = int'(afu_c1_tx.cl_len);
        end
    endtask

    task automatic do_reset();
        {rd_en, rsp_en, bp_en, hold_af} = '0;
        reset = 1'b1;
        repeat (3) step();
        reset = 1'b0;
    endtask

    task automatic stop_on_timeout(input string why);
        $display("Timeout: %s", why);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while ((tx_q.size() != 0 || exp_q.size() != 0 || beats_left != 0) && n < limit)
        begin
            step();
            n++;
        end
        if (tx_q.size() != 0 || exp_q.size() != 0 || beats_left != 0)
            stop_on_timeout("write beats still pending on fiu_c1_tx");
    endtask

    task automatic wait_almfull(input int limit);
        int n;
        n = 0;
        while (!afu_c1_almfull && n < limit)
        begin
            step();
            n++;
        end
        if (!afu_c1_almfull)
            stop_on_timeout("afu_c1_almfull never rose while the fabric was held full");
    endtask

    task automatic test_end(input string name);
        $display("Test %s: %0d checks, %0d errors", name, n_checks - chk0, errors - err0);
        chk0 = n_checks;
        err0 = errors;
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial
    begin
        clk          = 1'b0;
        split_writes = 1'b0;
        afu_c0_tx    = '0;
        afu_c1_tx    = '0;
        fiu_c0_rx    = '0;
        fiu_c1_rx    = '0;
        {fiu_c0_almfull, fiu_c1_almfull} = 2'b00;
        do_reset();

        rd_en = 1'b1;                        // 1: reads only
        repeat (200) step();
        rd_en = 1'b0;
        test_end("1 read pass-through");

        repeat (40) queue_packet(1'b0);      // 2: multi-line writes
        wait_drained(1000);
        test_end("2 multi-line writes");

        split_writes = 1'b1;                 // 3: tracker is idle here
        repeat (40) queue_packet(1'b0);
        wait_drained(1000);
        split_writes = 1'b0;
        test_end("3 split mode");

        bp_en = 1'b1;                        // 4: random then held fabric level
        repeat (30) queue_packet(1'b0);
        wait_drained(2000);
        hold_af = 1'b1;
        repeat (16) queue_packet(1'b0);
        wait_almfull(500);
        repeat (20) step();
        check_equal("afu_c1_almfull under hold", afu_c1_almfull, 1'b1);
        {hold_af, bp_en} = 2'b00;
        wait_drained(2000);
        test_end("4 back-pressure");

        rsp_en = 1'b1;                       // 5: responses and c0 level
        repeat (200) step();
        rsp_en = 1'b0;
        test_end("5 responses");

        check_equal("beat_error before injection", beat_error, 1'b0);
        queue_packet(1'b1);                  // 6: SOP on the second beat
        wait_drained(200);
        check_equal("beat_error after bad SOP", beat_error, 1'b1);
        repeat (10) step();
        check_equal("beat_error held", beat_error, 1'b1);
        do_reset();
        check_equal("beat_error after reset", beat_error, 1'b0);
        check_equal("fiu_c1_tx valid after reset", fiu_c1_tx.valid, 1'b0);
        check_equal("afu_c1_almfull after reset", afu_c1_almfull, 1'b0);
        test_end("6 SOP phase error");

        $display("Totals: %0d checks, %0d reads, %0d write beats, %0d responses, %0d errors",
                 n_checks, n_reads, n_beats, n_rsp, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
